/* bench/cdc_fifo_properties.sv */
module cdc_fifo_properties (
  input logic wr_clk,
  input logic rd_clk,
  input logic wr_rst_n,
  input logic rd_rst_n,
  input logic push_stb,
  input logic push_ack,
  input logic pop_stb,
  input logic pop_ack,
  input logic wr_en,
  input logic full,
  input logic rd_en,
  input logic empty
);
  timeunit 1ns;
  timeprecision 100ps;

  a_push_ack_stb: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    $rose(push_ack) |-> $past(push_stb)) else $error("push_ack rose without push_stb");
  a_push_ack_one: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    push_ack |=> !push_ack) else $error("push_ack held longer than one cycle");
  a_pop_ack_stb: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    $rose(pop_ack) |-> $past(pop_stb)) else $error("pop_ack rose without pop_stb");
  a_pop_ack_one: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    pop_ack |=> !pop_ack) else $error("pop_ack held longer than one cycle");
  a_push_full: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    $rose(wr_en) |-> !full) else $error("wr_en raised while full");
  a_pop_empty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    $rose(rd_en) |-> !empty) else $error("rd_en raised while empty");
  a_flags: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    !(full && empty)) else $error("full and empty high together");

endmodule

bind cdc_fifo_top cdc_fifo_properties i_props (
  .wr_clk, .rd_clk, .wr_rst_n, .rd_rst_n, .push_stb, .push_ack,
  .pop_stb, .pop_ack, .wr_en, .full, .rd_en, .empty
);

/* bench/cdc_fifo_tb.sv */
module cdc_fifo_tb
  import cdc_fifo_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  logic                  wr_clk, rd_clk, wr_rst_n;
  logic                  push_cyc, push_stb, push_we;
  wb_reg_e               push_adr;
  logic [DATA_WIDTH-1:0] push_dat_w, push_dat_r;
  logic                  pop_cyc, pop_stb, pop_we;
  wb_reg_e               pop_adr;
  logic [DATA_WIDTH-1:0] pop_dat_w, pop_dat_r;
  logic                  push_ack, pop_ack;

  string                 v_side[$];
  string                 v_rw[$];
  logic [1:0]            v_reg[$];
  logic [DATA_WIDTH-1:0] v_data[$];
  int                    v_settle[$];
  int                    v_count[$];
  int                    op_total;
  logic                  loaded;
  logic                  push_busy, pop_busy;
  logic [31:0]           lfsr;

  cdc_fifo_top i_cdc_fifo_top (.*);

  initial begin
    wr_clk = 1'b0;
    forever #7 wr_clk = ~wr_clk;
  end

  initial begin
    rd_clk = 1'b0;
    forever #10 rd_clk = ~rd_clk;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1);
  endtask

  // Fibonacci LFSR, taps 32, 22, 2 and 1; one new bit per call.
  function automatic logic next_bit();
    logic b;
    b    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], b};
    return b;
  endfunction

  task automatic push_xfer(input logic we, input logic [1:0] adr, input logic [15:0] val);
    @(posedge wr_clk);
    #1;
    push_cyc = 1'b1;
    push_stb = 1'b1;
    push_we = we;
    push_adr = wb_reg_e'(adr);
    push_dat_w = val;
    do begin
      @(posedge wr_clk);
      #1;
    end while (!push_ack);
    if (!we) begin
      assert (push_dat_r === val)
      else report_failure($sformatf("Error: push_dat_r is %h, expected %h", push_dat_r, val));
    end
    push_cyc = 1'b0;
    push_stb = 1'b0;
  endtask

  task automatic pop_xfer(input logic we, input logic [1:0] adr, input logic [15:0] val);
    @(posedge rd_clk);
    #1;
    pop_cyc = 1'b1;
    pop_stb = 1'b1;
    pop_we = we;
    pop_adr = wb_reg_e'(adr);
    pop_dat_w = val;
    do begin
      @(posedge rd_clk);
      #1;
    end while (!pop_ack);
    if (!we) begin
      assert (pop_dat_r === val)
      else report_failure($sformatf("Error: pop_dat_r is %h, expected %h", pop_dat_r, val));
    end
    pop_cyc = 1'b0;
    pop_stb = 1'b0;
  endtask

  task automatic run_op(input int i, input int k, input logic bg);
    logic we;
    we = (v_rw[i][0] == "w");
    if (v_side[i] == "push") begin
      push_xfer(we, v_reg[i], v_data[i] + 16'(k));
      if (bg) push_busy = 1'b0;
    end else begin
      pop_xfer(we, v_reg[i], v_data[i] + 16'(k));
      if (bg) pop_busy = 1'b0;
    end
  endtask

  task automatic run_vector(input int i);
    logic is_push;
    logic bg;
    is_push = (v_side[i] == "push");
    bg = (v_rw[i].len() > 1);
    if (is_push) wait (!push_busy); // A running transfer on the same port must finish first.
    else wait (!pop_busy);
    repeat (v_settle[i]) begin
      if (is_push) @(posedge wr_clk);
      else @(posedge rd_clk);
    end
    if (bg) begin
      if (is_push) push_busy = 1'b1;
      else pop_busy = 1'b1;
      fork
        run_op(i, 0, 1'b1);
      join_none
      repeat (20) begin
        if (is_push) @(posedge wr_clk);
        else @(posedge rd_clk);
      end
      assert (is_push ? push_busy : pop_busy)
      else report_failure($sformatf("Vector %0d was acknowledged while it should stall", i));
    end else begin
      for (int k = 0; k < v_count[i]; k++) begin
        run_op(i, k, 1'b0);
      end
    end
  endtask

  task automatic load_vectors();
    int    fd;
    string line, side, rw;
    int    r, settle, count;
    logic [15:0] adr, val;
    fd = $fopen("bench/cdc_fifo_vectors.txt", "r");
    if (fd == 0) report_failure("Could not open the vector file");
    while ($fgets(line, fd) > 0) begin
      if (line.len() < 2 || line[0] == "#") continue;
      r = $sscanf(line, "%s %s %h %h %d %d", side, rw, adr, val, settle, count);
      if (r != 6) report_failure($sformatf("Malformed vector line: %s", line));
      v_side.push_back(side);
      v_rw.push_back(rw);
      v_reg.push_back(adr[1:0]);
      v_data.push_back(val);
      v_settle.push_back(settle);
      v_count.push_back(count);
      op_total += count;
    end
    $fclose(fd);
  endtask

  // Limit scales with the operations in the vector file.
  initial begin
    wait (loaded);
    repeat (40 * op_total + 200) @(posedge rd_clk);
    report_failure("Timeout, the run did not finish within its cycle limit");
  end

  initial begin
    int gap;
    wr_rst_n = 1'b0;
    {push_cyc, push_stb, push_we, pop_cyc, pop_stb, pop_we} = '0;
    push_adr = REG_DATA;
    pop_adr = REG_DATA;
    push_dat_w = '0;
    pop_dat_w = '0;
    push_busy = 1'b0;
    pop_busy = 1'b0;
    lfsr = 32'h5a4e;
    op_total = 0;
    loaded = 1'b0;
    load_vectors();
    loaded = 1'b1;
    repeat (5) @(posedge rd_clk);
    #1 wr_rst_n = 1'b1;
    repeat (3) @(posedge rd_clk); // Read-side reset leaves on the second edge.
    for (int i = 0; i < v_side.size(); i++) begin
      run_vector(i);
      gap = {next_bit(), next_bit()};
      repeat (gap) @(posedge rd_clk);
    end
    wait (!push_busy && !pop_busy);
    $display("Regression passed");
    $finish;
  end

endmodule

/* bench/cdc_fifo_vectors.txt */
# side rw reg data settle count; rw is r or w, rb or wb leaves the transfer running
# data is write data or expected read data in hex and steps by one on each repeat
pop  r  1 000c 0  1
pop  r  2 0000 0  1
push w  0 1000 0  1
pop  r  1 0008 10 1
pop  r  2 0001 0  1
push w  0 1001 0  10
push r  1 0000 10 1
push r  2 000b 0  1
push w  0 100b 0  1
push r  1 0002 10 1
push w  0 100c 0  4
push r  1 0003 10 1
push r  2 0010 0  1
pop  r  1 0003 10 1
push wb 0 1010 0  1
pop  r  0 1000 0  13
pop  r  2 0004 10 1
pop  r  1 0000 0  1
pop  r  0 100d 0  1
pop  r  1 0000 10 1
pop  r  0 100e 0  1
pop  r  1 0008 10 1
pop  r  0 100f 0  2
pop  r  1 000c 10 1
pop  rb 0 2000 0  1
push w  0 2000 0  1
pop  r  1 000c 10 1

/* filelist.f */
src/cdc_fifo_pkg.sv
src/gray_ptr_sync.sv
src/dual_port_ram.sv
src/async_fifo.sv
src/wb_push_port.sv
src/wb_pop_port.sv
src/cdc_fifo_top.sv
bench/cdc_fifo_properties.sv
bench/cdc_fifo_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the mailbox testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module cdc_fifo_tb -o cdc_fifo_sim
if [ $? -ne 0 ]; then
  echo "Build with Verilator failed"
  exit 1
fi

./obj_dir/cdc_fifo_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
  exit 0
else
  echo "Pass message not found in $LOG"
  exit 1
fi

/* src/async_fifo.sv */
module async_fifo
  import cdc_fifo_pkg::*;
(
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  output logic [DATA_WIDTH-1:0] rd_data,
  output logic                  full,
  output logic                  afull,
  output logic [ADDR_WIDTH:0]   wr_level,
  output logic                  empty,
  output logic                  aempty,
  output logic [ADDR_WIDTH:0]   rd_level
);

  logic                wr_vld;
  logic [ADDR_WIDTH:0] wr_bin;
  logic [ADDR_WIDTH:0] wr_bin_nxt;
  logic [ADDR_WIDTH:0] wr_gray;
  logic [ADDR_WIDTH:0] wr_gray_nxt;
  logic [ADDR_WIDTH:0] rd_gray_wsync;
  logic [ADDR_WIDTH:0] rd_bin_wsync;
  logic [ADDR_WIDTH:0] wr_level_nxt;

  logic                rd_vld;
  logic [ADDR_WIDTH:0] rd_bin;
  logic [ADDR_WIDTH:0] rd_bin_nxt;
  logic [ADDR_WIDTH:0] rd_gray;
  logic [ADDR_WIDTH:0] rd_gray_nxt;
  logic [ADDR_WIDTH:0] wr_gray_rsync;
  logic [ADDR_WIDTH:0] wr_bin_rsync;
  logic [ADDR_WIDTH:0] rd_level_nxt;

  assign wr_vld = wr_en && !full;
  assign rd_vld = rd_en && !empty;

  dual_port_ram u_ram (
    .wr_clk  (wr_clk),
    .wr_en   (wr_vld),
    .wr_addr (wr_bin[ADDR_WIDTH-1:0]),
    .wr_data (wr_data),
    .rd_clk  (rd_clk),
    .rd_en   (rd_vld),
    .rd_addr (rd_bin[ADDR_WIDTH-1:0]),
    .rd_data (rd_data)
  );

  // Read pointer into the write domain.
  gray_ptr_sync u_rd2wr (
    .clk      (wr_clk),
    .rst_n    (wr_rst_n),
    .gray_in  (rd_gray),
    .gray_out (rd_gray_wsync),
    .bin_out  (rd_bin_wsync)
  );

  // Write pointer into the read domain.
  gray_ptr_sync u_wr2rd (
    .clk      (rd_clk),
    .rst_n    (rd_rst_n),
    .gray_in  (wr_gray),
    .gray_out (wr_gray_rsync),
    .bin_out  (wr_bin_rsync)
  );

  assign wr_bin_nxt   = wr_bin + (ADDR_WIDTH+1)'(wr_vld);
  assign wr_gray_nxt  = (wr_bin_nxt >> 1) ^ wr_bin_nxt;
  assign wr_level_nxt = wr_bin_nxt - rd_bin_wsync;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin   <= '0;
      wr_gray  <= '0;
      full     <= 1'b0;
      afull    <= 1'b0;
      wr_level <= '0;
    end else begin
      wr_bin   <= wr_bin_nxt;
      wr_gray  <= wr_gray_nxt;
      // Full when the pointers differ only in the wrap bit; in Gray that is the top two bits.
      full     <= (wr_gray_nxt == {~rd_gray_wsync[ADDR_WIDTH:ADDR_WIDTH-1],
                                   rd_gray_wsync[ADDR_WIDTH-2:0]});
      afull    <= (wr_level_nxt >= (ADDR_WIDTH+1)'(AFULL_LEVEL));
      wr_level <= wr_level_nxt;
    end
  end

  assign rd_bin_nxt   = rd_bin + (ADDR_WIDTH+1)'(rd_vld);
  assign rd_gray_nxt  = (rd_bin_nxt >> 1) ^ rd_bin_nxt;
  assign rd_level_nxt = wr_bin_rsync - rd_bin_nxt;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin   <= '0;
      rd_gray  <= '0;
      empty    <= 1'b1; // Nothing stored after reset.
      aempty   <= 1'b1;
      rd_level <= '0;
    end else begin
      rd_bin   <= rd_bin_nxt;
      rd_gray  <= rd_gray_nxt;
      empty    <= (rd_gray_nxt == wr_gray_rsync);
      aempty   <= (rd_level_nxt <= (ADDR_WIDTH+1)'(AEMPTY_LEVEL));
      rd_level <= rd_level_nxt;
    end
  end

endmodule

/* src/cdc_fifo_pkg.sv */
package cdc_fifo_pkg;

  // Word size and FIFO geometry.
  localparam int DATA_WIDTH = 16;
  localparam int FIFO_DEPTH = 16;
  localparam int ADDR_WIDTH = 4;

  // Fill-level thresholds for the almost flags.
  localparam int AFULL_LEVEL  = 12;
  localparam int AEMPTY_LEVEL = 2;

  // Bit positions in the status register.
  localparam int STAT_FULL   = 0;
  localparam int STAT_AFULL  = 1;
  localparam int STAT_EMPTY  = 2;
  localparam int STAT_AEMPTY = 3;

  // Word addresses, identical on both ports.
  typedef enum logic [1:0] {
    REG_DATA   = 2'd0, // Push on write, pop on read.
    REG_STATUS = 2'd1,
    REG_LEVEL  = 2'd2
  } wb_reg_e;

  // Wishbone slave states, shared by both ports.
  typedef enum logic [1:0] {
    PORT_IDLE,
    PORT_WAIT,
    PORT_ACK
  } port_state_e;

endpackage

/* src/cdc_fifo_top.sv */
module cdc_fifo_top
  import cdc_fifo_pkg::*;
(
  input  logic                  wr_clk,
  input  logic                  rd_clk,
  input  logic                  wr_rst_n,
  input  logic                  push_cyc,
  input  logic                  push_stb,
  input  logic                  push_we,
  input  wb_reg_e               push_adr,
  input  logic [DATA_WIDTH-1:0] push_dat_w,
  input  logic                  pop_cyc,
  input  logic                  pop_stb,
  input  logic                  pop_we,
  input  wb_reg_e               pop_adr,
  input  logic [DATA_WIDTH-1:0] pop_dat_w,
  output logic [DATA_WIDTH-1:0] push_dat_r,
  output logic [DATA_WIDTH-1:0] pop_dat_r,
  output logic                  push_ack,
  output logic                  pop_ack
);

  logic                  wr_en;
  logic [DATA_WIDTH-1:0] wr_data;
  logic                  full;
  logic                  afull;
  logic [ADDR_WIDTH:0]   wr_level;
  logic                  rd_en;
  logic                  rd_rst_n;
  logic [DATA_WIDTH-1:0] rd_data;
  logic                  empty;
  logic                  aempty;
  logic [ADDR_WIDTH:0]   rd_level;

  wb_push_port u_push (
    .wr_clk, .wr_rst_n, .push_cyc, .push_stb, .push_we, .push_adr, .push_dat_w,
    .full, .afull, .wr_level,
    .push_dat_r, .push_ack, .wr_en, .wr_data
  );

  async_fifo u_fifo (
    .wr_clk, .wr_rst_n, .wr_en, .wr_data,
    .rd_clk, .rd_rst_n, .rd_en,
    .rd_data, .full, .afull, .wr_level, .empty, .aempty, .rd_level
  );

  // Also owns the read-domain reset for the FIFO core.
  wb_pop_port u_pop (
    .rd_clk, .wr_rst_n, .pop_cyc, .pop_stb, .pop_we, .pop_adr, .pop_dat_w,
    .rd_data, .empty, .aempty, .rd_level,
    .pop_dat_r, .pop_ack, .rd_en, .rd_rst_n
  );

endmodule

/* src/dual_port_ram.sv */
module dual_port_ram
  import cdc_fifo_pkg::*;
(
  input  logic                  wr_clk,
  input  logic                  wr_en,
  input  logic [ADDR_WIDTH-1:0] wr_addr,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_en,
  input  logic [ADDR_WIDTH-1:0] rd_addr,
  output logic [DATA_WIDTH-1:0] rd_data
);

  logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Output register holds the last popped word between reads.
  always_ff @(posedge rd_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

/* src/gray_ptr_sync.sv */
module gray_ptr_sync
  import cdc_fifo_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic [ADDR_WIDTH:0] gray_in,
  output logic [ADDR_WIDTH:0] gray_out,
  output logic [ADDR_WIDTH:0] bin_out
);

  logic [ADDR_WIDTH:0] meta;

  // Only one bit of a Gray pointer moves per step, so two flops suffice.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      meta     <= '0;
      gray_out <= '0;
    end else begin
      meta     <= gray_in;
      gray_out <= meta;
    end
  end

  always_comb begin
    bin_out[ADDR_WIDTH] = gray_out[ADDR_WIDTH];
    for (int i = ADDR_WIDTH - 1; i >= 0; i--) begin
      bin_out[i] = bin_out[i+1] ^ gray_out[i];
    end
  end

endmodule

/* src/wb_pop_port.sv */
module wb_pop_port
  import cdc_fifo_pkg::*;
(
  input  logic                  rd_clk,
  input  logic                  wr_rst_n,
  input  logic                  pop_cyc,
  input  logic                  pop_stb,
  input  logic                  pop_we,
  input  wb_reg_e               pop_adr,
  input  logic [DATA_WIDTH-1:0] pop_dat_w,
  input  logic [DATA_WIDTH-1:0] rd_data,
  input  logic                  empty,
  input  logic                  aempty,
  input  logic [ADDR_WIDTH:0]   rd_level,
  output logic [DATA_WIDTH-1:0] pop_dat_r,
  output logic                  pop_ack,
  output logic                  rd_en,
  output logic                  rd_rst_n
);

  logic [1:0]            rst_sync;
  port_state_e           state;
  logic                  is_pop;
  logic                  data_sel;
  logic [DATA_WIDTH-1:0] status_word;
  logic [DATA_WIDTH-1:0] reg_value;
  logic [DATA_WIDTH-1:0] reg_q;

  // Reset enters asynchronously and leaves on the second rd_clk edge.
  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rst_sync <= 2'b00;
    end else begin
      rst_sync <= {rst_sync[0], 1'b1};
    end
  end

  assign rd_rst_n = rst_sync[1];
  assign is_pop   = !pop_we && (pop_adr == REG_DATA);

  always_comb begin
    status_word              = '0;
    status_word[STAT_FULL]   = (rd_level == (ADDR_WIDTH+1)'(FIFO_DEPTH));
    status_word[STAT_AFULL]  = (rd_level >= (ADDR_WIDTH+1)'(AFULL_LEVEL));
    status_word[STAT_EMPTY]  = empty;
    status_word[STAT_AEMPTY] = aempty;
    case (pop_adr)
      REG_STATUS: reg_value = status_word;
      REG_LEVEL:  reg_value = DATA_WIDTH'(rd_level);
      default:    reg_value = '0;
    endcase
  end

  // PORT_WAIT covers both the stall on empty and the RAM fetch cycle.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      state    <= PORT_IDLE;
      pop_ack  <= 1'b0;
      rd_en    <= 1'b0;
      data_sel <= 1'b0;
    end else begin
      pop_ack <= 1'b0;
      rd_en   <= 1'b0;
      case (state)
        PORT_IDLE: begin
          if (pop_cyc && pop_stb) begin
            data_sel <= is_pop;
            if (is_pop) begin
              rd_en <= !empty;
              state <= PORT_WAIT;
            end else begin
              pop_ack <= 1'b1; // Writes land here too and change nothing.
              state   <= PORT_ACK;
            end
          end
        end
        PORT_WAIT: begin
          if (rd_en) begin
            pop_ack <= 1'b1;
            state   <= PORT_ACK;
          end else if (!pop_cyc) begin
            state <= PORT_IDLE;
          end else begin
            rd_en <= !empty;
          end
        end
        default: state <= PORT_IDLE;
      endcase
    end
  end

  always_ff @(posedge rd_clk) begin
    if (state == PORT_IDLE && pop_cyc && pop_stb) begin
      reg_q <= pop_we ? pop_dat_w : reg_value;
    end
  end

  // The RAM output register already holds the popped word in the ack cycle.
  assign pop_dat_r = data_sel ? rd_data : reg_q;

endmodule

/* src/wb_push_port.sv */
module wb_push_port
  import cdc_fifo_pkg::*;
(
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  push_cyc,
  input  logic                  push_stb,
  input  logic                  push_we,
  input  wb_reg_e               push_adr,
  input  logic [DATA_WIDTH-1:0] push_dat_w,
  input  logic                  full,
  input  logic                  afull,
  input  logic [ADDR_WIDTH:0]   wr_level,
  output logic [DATA_WIDTH-1:0] push_dat_r,
  output logic                  push_ack,
  output logic                  wr_en,
  output logic [DATA_WIDTH-1:0] wr_data
);

  port_state_e           state;
  logic                  is_push;
  logic [DATA_WIDTH-1:0] status_word;
  logic [DATA_WIDTH-1:0] rd_value;

  assign is_push = push_we && (push_adr == REG_DATA);

  // Write-domain view of the flags; empty bits come from the write-side level.
  always_comb begin
    status_word              = '0;
    status_word[STAT_FULL]   = full;
    status_word[STAT_AFULL]  = afull;
    status_word[STAT_EMPTY]  = (wr_level == '0);
    status_word[STAT_AEMPTY] = (wr_level <= (ADDR_WIDTH+1)'(AEMPTY_LEVEL));
    case (push_adr)
      REG_STATUS: rd_value = status_word;
      REG_LEVEL:  rd_value = DATA_WIDTH'(wr_level);
      default:    rd_value = '0; // Data reads return zero.
    endcase
  end

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      state    <= PORT_IDLE;
      push_ack <= 1'b0;
      wr_en    <= 1'b0;
    end else begin
      push_ack <= 1'b0;
      wr_en    <= 1'b0;
      case (state)
        PORT_IDLE: begin
          if (push_cyc && push_stb) begin
            if (!is_push || !full) begin
              push_ack <= 1'b1;
              wr_en    <= is_push;
              state    <= PORT_ACK;
            end else begin
              state <= PORT_WAIT; // Hold the master off until space frees up.
            end
          end
        end
        PORT_WAIT: begin
          if (!push_cyc) begin
            state <= PORT_IDLE;
          end else if (!full) begin
            push_ack <= 1'b1;
            wr_en    <= 1'b1;
            state    <= PORT_ACK;
          end
        end
        default: state <= PORT_IDLE;
      endcase
    end
  end

  always_ff @(posedge wr_clk) begin
    if (state != PORT_ACK && push_cyc && push_stb) begin
      wr_data    <= push_dat_w;
      push_dat_r <= rd_value;
    end
  end

endmodule
